// ==== rtl/pgwr_pkg.sv ====
// ----------------------------------------
// shared types for the page-table write manager
// entry formats, bus packets, pointer ops, line geometry
// compile ahead of every rtl file
// ----------------------------------------
package pgwr_pkg;

	typedef logic [31:0] ptr_t; // entry index, 0 is null

	// att status codes
	typedef enum logic [1:0] {
		STS_DALLOC = 2'd0,
		STS_UNCOMP = 2'd1
	} att_sts_t;

	typedef struct packed {
		logic [13:0] zpd_cnt;
		logic [47:0] way;
		att_sts_t    sts;
	} att_entry_t; // 64 bits

	typedef struct packed {
		logic [13:0] rsvd;
		logic [49:0] way;
		ptr_t        prev; // bytes 4..7 of the entry
		ptr_t        next; // bytes 0..3
	} list_entry_t; // 128 bits

	// line geometry
	localparam int LINE_BYTES    = 64;
	localparam int ATT_BYTES     = 8;
	localparam int LIST_BYTES    = 16;
	localparam int PTR_BYTES     = 4;
	localparam int ATT_PER_LINE  = LINE_BYTES / ATT_BYTES;  // 8
	localparam int LIST_PER_LINE = LINE_BYTES / LIST_BYTES; // 4
	localparam int ATT_SLOT_W    = $clog2(ATT_PER_LINE);
	localparam int LIST_SLOT_W   = $clog2(LIST_PER_LINE);

	// write port
	typedef struct packed {
		logic [63:0]  addr; // line aligned
		logic [511:0] data;
		logic [63:0]  strb;
	} axi_wr_pld_t;

	typedef struct packed {
		axi_wr_pld_t pld;
		logic        awvalid; // one cycle pulse
		logic        wvalid;  // one cycle pulse, never with awvalid
	} axi_wr_req_t;

	typedef struct packed {
		logic awready;
		logic wready;
	} axi_wr_rdy_t;

	typedef struct packed {
		logic       bvalid;
		logic [1:0] bresp; // 0 is okay
	} axi_wr_resp_t;

	// table update request
	typedef struct packed {
		logic        tbl_update; // pulse
		ptr_t        att_id;
		ptr_t        tol_id;     // list entry moved free -> uncomp
		list_entry_t lst_entry;  // current contents of tol_id
	} tol_upd_t;

	typedef struct packed {
		ptr_t free_head;
		ptr_t free_tail;
		ptr_t uncomp_head;
		ptr_t uncomp_tail;
	} tol_ht_t;

	// one table write each
	typedef enum logic [2:0] {
		STEP_INIT_ATT,
		STEP_INIT_LIST,
		STEP_ATT_ALLOC,
		STEP_POP_FREE,
		STEP_PUSH_SELF,
		STEP_PUSH_LINK
	} step_t;

	// pulses from decode to the list registers
	typedef struct packed {
		logic att_done;
		logic list_done;
		ptr_t list_tail;   // with list_done
		logic pop_free;
		ptr_t new_head;    // with pop_free
		logic push_uncomp;
		ptr_t id;          // with push_uncomp
	} ptr_op_t;

endpackage

// ==== rtl/pgwr_cmd_decode.sv ====
// ----------------------------------------
// mode sequencer of the write manager
// turns init levels and update pulses into table-write steps
// ----------------------------------------
`timescale 1ns/1ps

module pgwr_cmd_decode #(
	parameter int ATT_ENTRIES  = 16,
	parameter int LIST_ENTRIES = 8
) (
	input  logic               clk_i,
	input  logic               rst_ni,
	input  logic               init_att,
	input  logic               init_list,
	input  pgwr_pkg::tol_upd_t tol_updpkt,
	input  logic               init_att_done,
	input  logic               init_list_done,
	input  logic               uncomp_empty,
	input  logic               line_sent,
	input  logic               resp_idle,
	output pgwr_pkg::step_t    step,
	output pgwr_pkg::ptr_t     entry_idx,
	output pgwr_pkg::tol_upd_t upd,
	output logic               start,
	output pgwr_pkg::ptr_op_t  ptr_op,
	output logic               pgwr_mngr_ready,
	output logic               tbl_update_done
);
	import pgwr_pkg::*;

	typedef enum logic [1:0] {
		D_IDLE,
		D_WRITE, // one line in flight at issue
		D_RESP   // draining responses after the last update write
	} dstate_t;

	dstate_t  state_q;
	step_t    step_q;
	ptr_t     idx_q;
	tol_upd_t upd_q;
	logic     start_q;
	logic     pend_q; // line handed to issue, not yet sent
	logic     att_go, list_go, upd_go;
	logic     last_att, last_list;

	// idle priority is att init, then list init, then update
	assign att_go  = (state_q == D_IDLE) && init_att && !init_att_done;
	assign list_go = (state_q == D_IDLE) && init_list && !init_list_done && !att_go;
	assign upd_go  = (state_q == D_IDLE) && tol_updpkt.tbl_update && !att_go && !list_go;

	assign last_att  = idx_q == ptr_t'(ATT_ENTRIES);
	assign last_list = idx_q == ptr_t'(LIST_ENTRIES);

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q <= D_IDLE;
			step_q  <= STEP_INIT_ATT;
			idx_q   <= '0;
			start_q <= 1'b0;
		end else begin
			start_q <= 1'b0; // pulse
			case (state_q)
				D_IDLE: begin
					if (att_go || list_go || upd_go) begin
						state_q <= D_WRITE;
						start_q <= 1'b1;
						idx_q   <= ptr_t'(1); // tables start at entry 1
					end
					if (att_go)
						step_q <= STEP_INIT_ATT;
					else if (list_go)
						step_q <= STEP_INIT_LIST;
					else if (upd_go)
						step_q <= STEP_ATT_ALLOC;
				end
				D_WRITE: begin
					if (line_sent) begin
						start_q <= 1'b1; // next line by default
						case (step_q)
							STEP_INIT_ATT, STEP_INIT_LIST: begin
								idx_q <= idx_q + ptr_t'(1);
								if ((step_q == STEP_INIT_ATT) ? last_att : last_list) begin
									state_q <= D_IDLE;
									start_q <= 1'b0;
								end
							end
							STEP_ATT_ALLOC: step_q <= STEP_POP_FREE;
							STEP_POP_FREE:  step_q <= STEP_PUSH_SELF;
							STEP_PUSH_SELF: begin
								if (uncomp_empty) begin // no old tail to link
									state_q <= D_RESP;
									start_q <= 1'b0;
								end else begin
									step_q <= STEP_PUSH_LINK;
								end
							end
							default: begin // push link was last
								state_q <= D_RESP;
								start_q <= 1'b0;
							end
						endcase
					end
				end
				default: begin
					if (resp_idle)
						state_q <= D_IDLE;
				end
			endcase
		end
	end

	// set by start, cleared when issue reports the data beat
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni)
			pend_q <= 1'b0;
		else if (start_q)
			pend_q <= 1'b1;
		else if (line_sent)
			pend_q <= 1'b0;
	end

	// request payload
	always_ff @(posedge clk_i) begin
		if (upd_go)
			upd_q <= tol_updpkt;
	end

	// pointer ops land with the line_sent of the step that owns them
	always_comb begin
		ptr_op           = '0;
		ptr_op.list_tail = ptr_t'(LIST_ENTRIES);
		ptr_op.new_head  = upd_q.lst_entry.next; // popped entry's next
		ptr_op.id        = upd_q.tol_id;
		if (state_q == D_WRITE && line_sent) begin
			case (step_q)
				STEP_INIT_ATT:  ptr_op.att_done    = last_att;
				STEP_INIT_LIST: ptr_op.list_done   = last_list;
				STEP_POP_FREE:  ptr_op.pop_free    = 1'b1;
				STEP_PUSH_SELF: ptr_op.push_uncomp = uncomp_empty;
				STEP_PUSH_LINK: ptr_op.push_uncomp = 1'b1; // tail moves after link
				default:        ptr_op.pop_free    = 1'b0;
			endcase
		end
	end

	assign step            = step_q;
	assign entry_idx       = idx_q;
	assign upd             = upd_q;
	assign start           = start_q;
	assign pgwr_mngr_ready = state_q == D_IDLE;
	assign tbl_update_done = (state_q == D_RESP) && resp_idle;

	// a new line goes to issue only once the previous one is out
	a_start_no_overlap: assert property (@(posedge clk_i) disable iff (!rst_ni)
		start |-> !pend_q);

	// issue reports a data beat only for a line it was given
	a_sent_was_pending: assert property (@(posedge clk_i) disable iff (!rst_ni)
		line_sent |-> pend_q);

endmodule

// ==== rtl/pgwr_line_build.sv ====
// ----------------------------------------
// builds address, data and strobes of one table write
// purely combinational, issue samples it on start
// ----------------------------------------
`timescale 1ns/1ps

module pgwr_line_build #(
	parameter logic [63:0] ATT_BASE  = 64'h0,
	parameter logic [63:0] LIST_BASE = 64'h0,
	parameter logic [49:0] PPA_BASE  = 50'h0
) (
	input  pgwr_pkg::step_t       step,
	input  pgwr_pkg::ptr_t        entry_idx,
	input  pgwr_pkg::tol_upd_t    upd,
	input  pgwr_pkg::tol_ht_t     tol_ht,
	output pgwr_pkg::axi_wr_pld_t line
);
	import pgwr_pkg::*;

	ptr_t                   tgt;     // entry being written
	ptr_t                   ofs;     // zero based index
	ptr_t                   line_no;
	logic                   is_att;
	logic [ATT_SLOT_W-1:0]  att_slot;
	logic [LIST_SLOT_W-1:0] lst_slot;
	att_entry_t             att_e;
	list_entry_t            lst_e;

	always_comb begin
		case (step)
			STEP_INIT_ATT, STEP_INIT_LIST: tgt = entry_idx;
			STEP_ATT_ALLOC: tgt = upd.att_id;
			STEP_POP_FREE:  tgt = upd.lst_entry.next;   // successor of popped head
			STEP_PUSH_SELF: tgt = upd.tol_id;
			default:        tgt = tol_ht.uncomp_tail; // old tail gets the link
		endcase
	end

	assign is_att   = (step == STEP_INIT_ATT) || (step == STEP_ATT_ALLOC);
	assign ofs      = tgt - ptr_t'(1);
	assign line_no  = is_att ? ofs / ptr_t'(ATT_PER_LINE) : ofs / ptr_t'(LIST_PER_LINE);
	assign att_slot = ATT_SLOT_W'(ofs % ptr_t'(ATT_PER_LINE));
	assign lst_slot = LIST_SLOT_W'(ofs % ptr_t'(LIST_PER_LINE));

	// att entry: deallocated on init, uncomp on alloc
	always_comb begin
		att_e.zpd_cnt = '0;
		att_e.way     = '0;
		att_e.sts     = STS_DALLOC;
		if (step == STEP_ATT_ALLOC) begin
			att_e.way = upd.lst_entry.way[47:0];
			att_e.sts = STS_UNCOMP;
		end
	end

	// init list entry, chained to both neighbours
	always_comb begin
		lst_e.rsvd = '0;
		lst_e.way  = PPA_BASE + 50'(ofs); // one page per entry
		lst_e.prev = ofs;
		lst_e.next = entry_idx + ptr_t'(1);
	end

	always_comb begin
		line.addr = (is_att ? ATT_BASE : LIST_BASE) + 64'(line_no) * 64'(LINE_BYTES);
		line.data = '0;
		line.strb = '0; // untouched bytes stay masked
		case (step)
			STEP_INIT_ATT, STEP_ATT_ALLOC: begin
				line.data[att_slot*ATT_BYTES*8 +: ATT_BYTES*8] = att_e;
				line.strb[att_slot*ATT_BYTES +: ATT_BYTES]     = '1;
			end
			STEP_INIT_LIST: begin
				line.data[lst_slot*LIST_BYTES*8 +: LIST_BYTES*8] = lst_e;
				line.strb[lst_slot*LIST_BYTES +: LIST_BYTES]     = '1;
			end
			STEP_POP_FREE: begin // prev word only
				line.data[lst_slot*LIST_BYTES*8 + PTR_BYTES*8 +: PTR_BYTES*8] = upd.lst_entry.prev;
				line.strb[lst_slot*LIST_BYTES + PTR_BYTES +: PTR_BYTES]       = '1;
			end
			STEP_PUSH_SELF: begin // prev = old tail, next = null
				line.data[lst_slot*LIST_BYTES*8 +: 2*PTR_BYTES*8] = {tol_ht.uncomp_tail, ptr_t'(0)};
				line.strb[lst_slot*LIST_BYTES +: 2*PTR_BYTES]     = '1;
			end
			default: begin // next word of old tail
				line.data[lst_slot*LIST_BYTES*8 +: PTR_BYTES*8] = upd.tol_id;
				line.strb[lst_slot*LIST_BYTES +: PTR_BYTES]     = '1;
			end
		endcase
	end

endmodule

// ==== rtl/pgwr_axi_wr_issue.sv ====
// ----------------------------------------
// write issue: address pulse, then data pulse
// also tracks responses still owed by memory
// ----------------------------------------
`timescale 1ns/1ps

module pgwr_axi_wr_issue (
	input  logic                   clk_i,
	input  logic                   rst_ni,
	input  logic                   start,
	input  pgwr_pkg::axi_wr_pld_t  line,
	input  pgwr_pkg::axi_wr_rdy_t  wr_rdypkt,
	input  pgwr_pkg::axi_wr_resp_t wr_resppkt,
	output pgwr_pkg::axi_wr_req_t  wr_reqpkt,
	output logic                   line_sent,
	output logic                   resp_idle
);
	import pgwr_pkg::*;

	typedef enum logic [1:0] {
		I_IDLE,
		I_WAIT_AW,
		I_WAIT_W
	} istate_t;

	istate_t     state_q;
	axi_wr_pld_t pld_q;
	logic        awvalid_q, wvalid_q;
	logic [7:0]  outst_q; // responses owed
	logic        resp_ok;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q   <= I_IDLE;
			awvalid_q <= 1'b0;
			wvalid_q  <= 1'b0;
		end else begin
			awvalid_q <= 1'b0; // both are single cycle
			wvalid_q  <= 1'b0;
			case (state_q)
				I_IDLE: begin
					if (start)
						state_q <= I_WAIT_AW;
				end
				I_WAIT_AW: begin
					if (wr_rdypkt.awready && !awvalid_q) begin
						awvalid_q <= 1'b1;
						state_q   <= I_WAIT_W;
					end
				end
				default: begin
					if (wr_rdypkt.wready && !wvalid_q) begin
						wvalid_q <= 1'b1; // same payload as the address beat
						state_q  <= I_IDLE;
					end
				end
			endcase
		end
	end

	// payload holds until next start
	always_ff @(posedge clk_i) begin
		if (start && state_q == I_IDLE)
			pld_q <= line;
	end

	assign resp_ok = wr_resppkt.bvalid && (wr_resppkt.bresp == 2'b00);

	// awvalid only rises after awready, so each pulse is an accepted address
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni)
			outst_q <= '0;
		else if (awvalid_q && !resp_ok)
			outst_q <= outst_q + 8'd1;
		else if (resp_ok && !awvalid_q)
			outst_q <= outst_q - 8'd1;
	end

	assign wr_reqpkt.pld     = pld_q;
	assign wr_reqpkt.awvalid = awvalid_q;
	assign wr_reqpkt.wvalid  = wvalid_q;
	assign line_sent         = wvalid_q;
	assign resp_idle         = outst_q == '0;

	a_no_stray_resp: assert property (@(posedge clk_i) disable iff (!rst_ni)
		wr_resppkt.bvalid |-> outst_q != '0);

	a_aw_w_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
		!(wr_reqpkt.awvalid && wr_reqpkt.wvalid));

endmodule

// ==== rtl/tol_list_regs.sv ====
// ----------------------------------------
// list head and tail pointers plus sticky init flags
// updated only by pointer-op pulses from decode
// ----------------------------------------
`timescale 1ns/1ps

module tol_list_regs (
	input  logic              clk_i,
	input  logic              rst_ni,
	input  pgwr_pkg::ptr_op_t ptr_op,
	output pgwr_pkg::tol_ht_t tol_ht,
	output logic              init_att_done,
	output logic              init_list_done,
	output logic              uncomp_empty
);
	import pgwr_pkg::*;

	tol_ht_t ht_q;
	logic    att_done_q, list_done_q;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			ht_q        <= '0; // all lists null
			att_done_q  <= 1'b0;
			list_done_q <= 1'b0;
		end else begin
			if (ptr_op.att_done)
				att_done_q <= 1'b1; // sticky
			if (ptr_op.list_done) begin
				list_done_q    <= 1'b1;
				ht_q.free_head <= ptr_t'(1); // whole table is one free list
				ht_q.free_tail <= ptr_op.list_tail;
			end
			if (ptr_op.pop_free)
				ht_q.free_head <= ptr_op.new_head;
			if (ptr_op.push_uncomp) begin
				ht_q.uncomp_tail <= ptr_op.id;
				if (ht_q.uncomp_tail == '0) // first entry is head too
					ht_q.uncomp_head <= ptr_op.id;
			end
		end
	end

	assign tol_ht         = ht_q;
	assign init_att_done  = att_done_q;
	assign init_list_done = list_done_q;
	assign uncomp_empty   = ht_q.uncomp_tail == '0;

endmodule

// ==== rtl/pgwr_mngr.sv ====
// ----------------------------------------
// page-table write manager top
// table sizes and base addresses are set here
// ----------------------------------------
`timescale 1ns/1ps

module pgwr_mngr #(
	parameter int          ATT_ENTRIES  = 16,
	parameter int          LIST_ENTRIES = 8,
	parameter logic [63:0] ATT_BASE     = 64'h0000_0000_8000_0000,
	parameter logic [63:0] LIST_BASE    = 64'h0000_0000_8001_0000,
	parameter logic [49:0] PPA_BASE     = 50'h0_0000_0008_0100
) (
	input  logic                   clk_i,
	input  logic                   rst_ni,
	input  logic                   init_att,
	input  logic                   init_list,
	input  pgwr_pkg::tol_upd_t     tol_updpkt,
	input  pgwr_pkg::axi_wr_rdy_t  wr_rdypkt,
	input  pgwr_pkg::axi_wr_resp_t wr_resppkt,
	output pgwr_pkg::axi_wr_req_t  wr_reqpkt,
	output pgwr_pkg::tol_ht_t      tol_ht,
	output logic                   init_att_done,
	output logic                   init_list_done,
	output logic                   pgwr_mngr_ready,
	output logic                   tbl_update_done
);
	import pgwr_pkg::*;

	step_t       step;
	ptr_t        entry_idx;
	tol_upd_t    upd;
	ptr_op_t     ptr_op;
	axi_wr_pld_t line;
	logic        start, line_sent, resp_idle, uncomp_empty;

	pgwr_cmd_decode #(
		.ATT_ENTRIES  (ATT_ENTRIES),
		.LIST_ENTRIES (LIST_ENTRIES)
	) u_decode (
		.clk_i, .rst_ni,
		.init_att, .init_list, .tol_updpkt,
		.init_att_done, .init_list_done, .uncomp_empty,
		.line_sent, .resp_idle,
		.step, .entry_idx, .upd, .start, .ptr_op,
		.pgwr_mngr_ready, .tbl_update_done
	);

	pgwr_line_build #(
		.ATT_BASE  (ATT_BASE),
		.LIST_BASE (LIST_BASE),
		.PPA_BASE  (PPA_BASE)
	) u_line_build (
		.step, .entry_idx, .upd, .tol_ht,
		.line
	);

	pgwr_axi_wr_issue u_issue (
		.clk_i, .rst_ni,
		.start, .line,
		.wr_rdypkt, .wr_resppkt, .wr_reqpkt,
		.line_sent, .resp_idle
	);

	tol_list_regs u_list_regs (
		.clk_i, .rst_ni,
		.ptr_op,
		.tol_ht, .init_att_done, .init_list_done, .uncomp_empty
	);

endmodule

// ==== verification/pgwr_mem_model.sv ====
// ----------------------------------------
// write slave for the table manager testbench
// random ready and response delay, strobed writes land in shadow tables
// ----------------------------------------
`timescale 1ns/1ps

module pgwr_mem_model #(
	parameter int          ATT_ENTRIES  = 16,
	parameter int          LIST_ENTRIES = 8,
	parameter logic [63:0] ATT_BASE     = 64'h0,
	parameter logic [63:0] LIST_BASE    = 64'h0,
	parameter logic [31:0] SEED         = 32'h1
) (
	input  logic                   clk_i,
	input  logic                   rst_ni,
	input  pgwr_pkg::axi_wr_req_t  wr_reqpkt,
	output pgwr_pkg::axi_wr_rdy_t  wr_rdypkt,
	output pgwr_pkg::axi_wr_resp_t wr_resppkt
);
	import pgwr_pkg::*;

	att_entry_t   att_tbl [1:ATT_ENTRIES];   // read by the testbench
	list_entry_t  list_tbl [1:LIST_ENTRIES];
	int           owed;      // addresses seen minus responses given
	int           stray_cnt; // writes outside both tables
	int           cyc;
	int           due_q [$]; // response due cycles, in order
	logic [31:0]  rnd;
	axi_wr_rdy_t  rdy_n;
	axi_wr_resp_t resp_n;

	function automatic logic [31:0] lcg_next(logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// byte-wise merge of one line into the shadow tables
	task automatic apply_write(axi_wr_pld_t p);
		logic [63:0] ofs;
		int          idx, s, b;
		att_entry_t  ae;
		list_entry_t le;
		if (p.addr >= LIST_BASE) begin
			ofs = p.addr - LIST_BASE;
			for (s = 0; s < LIST_PER_LINE; s++) begin
				idx = int'(ofs / 64'(LINE_BYTES)) * LIST_PER_LINE + s + 1;
				if (p.strb[s*LIST_BYTES +: LIST_BYTES] != '0) begin
					if (idx > LIST_ENTRIES) begin
						stray_cnt++; // past the table end
					end else begin
						le = list_tbl[idx];
						for (b = 0; b < LIST_BYTES; b++)
							if (p.strb[s*LIST_BYTES + b])
								le[b*8 +: 8] = p.data[(s*LIST_BYTES + b)*8 +: 8];
						list_tbl[idx] = le;
					end
				end
			end
		end else if (p.addr >= ATT_BASE) begin
			ofs = p.addr - ATT_BASE;
			for (s = 0; s < ATT_PER_LINE; s++) begin
				idx = int'(ofs / 64'(LINE_BYTES)) * ATT_PER_LINE + s + 1;
				if (p.strb[s*ATT_BYTES +: ATT_BYTES] != '0) begin
					if (idx > ATT_ENTRIES) begin
						stray_cnt++;
					end else begin
						ae = att_tbl[idx];
						for (b = 0; b < ATT_BYTES; b++)
							if (p.strb[s*ATT_BYTES + b])
								ae[b*8 +: 8] = p.data[(s*ATT_BYTES + b)*8 +: 8];
						att_tbl[idx] = ae;
					end
				end
			end
		end else begin
			stray_cnt++; // below both bases
		end
	endtask

	initial begin
		int i;
		rnd        = SEED;
		cyc        = 0;
		owed       = 0;
		stray_cnt  = 0;
		rdy_n      = '0;
		resp_n     = '0;
		wr_rdypkt  = '0;
		wr_resppkt = '0;
		// fill with index-dependent junk so missed writes show up
		for (i = 1; i <= ATT_ENTRIES; i++)
			att_tbl[i] = {~32'(i), 32'(i) ^ 32'hdead_0000};
		for (i = 1; i <= LIST_ENTRIES; i++)
			list_tbl[i] = {4{32'(i) ^ 32'h5a5a_0000}};
		forever begin
			@(posedge clk_i);
			if (!rst_ni) begin
				due_q.delete();
				owed   = 0;
				rdy_n  = '0;
				resp_n = '0;
			end else begin
				if (wr_reqpkt.awvalid)
					owed++;
				if (wr_resppkt.bvalid)
					owed--; // consumed by the dut at this edge
				if (wr_reqpkt.wvalid) begin
					apply_write(wr_reqpkt.pld);
					rnd = lcg_next(rnd);
					due_q.push_back(cyc + int'(rnd[31:27]) % 6); // 0..5 cycles
				end
				resp_n = '0;
				if (due_q.size() != 0 && due_q[0] <= cyc) begin
					resp_n.bvalid = 1'b1; // bresp stays okay
					void'(due_q.pop_front());
				end
				rnd           = lcg_next(rnd);
				rdy_n.awready = rnd[21:20] != 2'b00; // about 3 in 4
				rdy_n.wready  = rnd[29:28] != 2'b00;
			end
			cyc++;
			#1;
			wr_rdypkt  = rdy_n;
			wr_resppkt = resp_n;
		end
	end

endmodule

// ==== verification/tb_pgwr_mngr.sv ====
// ----------------------------------------
// testbench for the page-table write manager
// att init, list init, then updates checked against a reference model
// ----------------------------------------
`timescale 1ns/1ps

module tb_pgwr_mngr;
	import pgwr_pkg::*;

	localparam int          ATT_ENTRIES  = 16;
	localparam int          LIST_ENTRIES = 8;
	localparam logic [63:0] ATT_BASE     = 64'h0000_0000_8000_0000;
	localparam logic [63:0] LIST_BASE    = 64'h0000_0000_8001_0000;
	localparam logic [49:0] PPA_BASE     = 50'h0_0000_0008_0100;
	localparam int          NUM_UPD      = 6;
	localparam int          CYC_LIMIT    = 40 * (ATT_ENTRIES + LIST_ENTRIES + 4 * NUM_UPD) + 200;

	logic         clk_i = 1'b0;
	logic         rst_ni;
	logic         init_att, init_list;
	tol_upd_t     tol_updpkt;
	axi_wr_rdy_t  wr_rdypkt;
	axi_wr_resp_t wr_resppkt;
	axi_wr_req_t  wr_reqpkt;
	tol_ht_t      tol_ht;
	logic         init_att_done, init_list_done, pgwr_mngr_ready, tbl_update_done;

	att_entry_t  exp_att [1:ATT_ENTRIES]; // expected tables
	list_entry_t exp_list [1:LIST_ENTRIES];
	tol_ht_t     exp_ht;
	logic [31:0] rnd_q;
	int          val_err, acc_cnt, cyc;
	int          proto_err = 0; // owned by the monitor
	int          done_cnt  = 0;

	always #4 clk_i = ~clk_i; // 8 ns

	pgwr_mngr #(
		.ATT_ENTRIES  (ATT_ENTRIES),
		.LIST_ENTRIES (LIST_ENTRIES),
		.ATT_BASE     (ATT_BASE),
		.LIST_BASE    (LIST_BASE),
		.PPA_BASE     (PPA_BASE)
	) u_pgwr_mngr (
		.clk_i, .rst_ni, .init_att, .init_list, .tol_updpkt,
		.wr_rdypkt, .wr_resppkt, .wr_reqpkt, .tol_ht,
		.init_att_done, .init_list_done, .pgwr_mngr_ready, .tbl_update_done
	);

	pgwr_mem_model #(
		.ATT_ENTRIES  (ATT_ENTRIES),
		.LIST_ENTRIES (LIST_ENTRIES),
		.ATT_BASE     (ATT_BASE),
		.LIST_BASE    (LIST_BASE),
		.SEED         (32'h5e73)
	) u_mem (
		.clk_i, .rst_ni, .wr_reqpkt, .wr_rdypkt, .wr_resppkt
	);

	function automatic logic [31:0] next_rand(logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// list entry right after init, chained to both neighbours
	function automatic list_entry_t init_list_ref(int idx);
		list_entry_t e;
		e.rsvd = '0;
		e.way  = PPA_BASE + 50'(idx - 1);
		e.prev = ptr_t'(idx - 1);
		e.next = ptr_t'(idx + 1);
		return e;
	endfunction

	// one update: alloc att, pop free head, push onto uncomp tail
	function automatic void ref_update(ptr_t att_id, ptr_t tol_id);
		list_entry_t e;
		e = exp_list[int'(tol_id)];
		exp_att[int'(att_id)].zpd_cnt = '0;
		exp_att[int'(att_id)].way     = e.way[47:0];
		exp_att[int'(att_id)].sts     = STS_UNCOMP;
		exp_list[int'(e.next)].prev = e.prev; // successor becomes head
		exp_ht.free_head = e.next;
		exp_list[int'(tol_id)].prev = exp_ht.uncomp_tail;
		exp_list[int'(tol_id)].next = '0;
		if (exp_ht.uncomp_tail == '0)
			exp_ht.uncomp_head = tol_id; // first in list
		else
			exp_list[int'(exp_ht.uncomp_tail)].next = tol_id;
		exp_ht.uncomp_tail = tol_id;
	endfunction

	task automatic check_att_entry(string name, att_entry_t exp, att_entry_t act);
		if (act !== exp) begin
			val_err++;
			$display("ERR %0t %s exp=%h act=%h", $time, name, exp, act);
		end
	endtask

	task automatic check_list_entry(string name, list_entry_t exp, list_entry_t act);
		if (act !== exp) begin
			val_err++;
			$display("ERR %0t %s exp=%h act=%h", $time, name, exp, act);
		end
	endtask

	task automatic check_tol_ht(string name, tol_ht_t exp, tol_ht_t act);
		if (act !== exp) begin
			val_err++;
			$display("ERR %0t %s exp=%h act=%h", $time, name, exp, act);
		end
	endtask

	task automatic check_flag(string name, logic exp, logic act);
		if (act !== exp) begin
			val_err++;
			$display("ERR %0t %s exp=%b act=%b", $time, name, exp, act);
		end
	endtask

	task automatic check_count(string name, int exp, int act);
		if (act != exp) begin
			val_err++;
			$display("ERR %0t %s exp=%0d act=%0d", $time, name, exp, act);
		end
	endtask

	// shadow tables and pointers against the model
	task automatic compare_tables(logic with_list);
		int i;
		for (i = 1; i <= ATT_ENTRIES; i++)
			check_att_entry($sformatf("att_tbl[%0d]", i), exp_att[i], u_mem.att_tbl[i]);
		if (with_list)
			for (i = 1; i <= LIST_ENTRIES; i++)
				check_list_entry($sformatf("list_tbl[%0d]", i), exp_list[i], u_mem.list_tbl[i]);
		check_tol_ht("tol_ht", exp_ht, tol_ht);
	endtask

	task automatic drive_slot();
		@(posedge clk_i);
		#1; // inputs change just after the edge
	endtask

	task automatic run_update(logic send_stray);
		ptr_t att_id, tol_id;
		@(negedge clk_i);
		while (!pgwr_mngr_ready)
			@(negedge clk_i);
		rnd_q  = next_rand(rnd_q);
		att_id = ptr_t'(int'(rnd_q[23:16]) % ATT_ENTRIES + 1);
		tol_id = exp_ht.free_head; // always move the free head
		drive_slot();
		tol_updpkt.tbl_update = 1'b1;
		tol_updpkt.att_id     = att_id;
		tol_updpkt.tol_id     = tol_id;
		tol_updpkt.lst_entry  = exp_list[int'(tol_id)];
		ref_update(att_id, tol_id);
		drive_slot();
		tol_updpkt.tbl_update = 1'b0;
		acc_cnt++;
		if (send_stray) begin // busy, so this one must be dropped
			drive_slot();
			check_flag("pgwr_mngr_ready", 1'b0, pgwr_mngr_ready);
			tol_updpkt.tbl_update = 1'b1;
			tol_updpkt.att_id     = ptr_t'(ATT_ENTRIES);
			tol_updpkt.tol_id     = ptr_t'(LIST_ENTRIES);
			tol_updpkt.lst_entry  = '1;
			drive_slot();
			tol_updpkt.tbl_update = 1'b0;
		end
		@(negedge clk_i);
		while (!tbl_update_done)
			@(negedge clk_i);
		drive_slot();
		check_flag("pgwr_mngr_ready", 1'b1, pgwr_mngr_ready);
		compare_tables(1'b1);
	endtask

	// done pulses, response drain and ready level during updates
	always @(negedge clk_i) begin
		if (rst_ni) begin
			if (tbl_update_done) begin
				if (acc_cnt == done_cnt) begin
					proto_err++;
					$display("update done pulse at %0t with no update pending", $time);
				end
				if (u_mem.owed != 0) begin
					proto_err++;
					$display("update done at %0t while %0d responses are owed", $time, u_mem.owed);
				end
				done_cnt++;
			end else if (acc_cnt != done_cnt && pgwr_mngr_ready) begin
				proto_err++;
				$display("manager ready at %0t in the middle of an update", $time);
			end
		end
	end

	initial begin
		cyc = 0;
		while (cyc < CYC_LIMIT) begin
			@(posedge clk_i);
			cyc++;
		end
		$display("timeout, run did not finish within %0d cycles", CYC_LIMIT);
		$display("run over: %0d value errors, %0d protocol errors", val_err, proto_err);
		$display("Errors found");
		$finish;
	end

	initial begin
		int i;
		rst_ni     = 1'b0;
		init_att   = 1'b0;
		init_list  = 1'b0;
		tol_updpkt = '0;
		val_err    = 0;
		acc_cnt    = 0;
		rnd_q      = 32'h5e73;
		exp_ht     = '0;
		for (i = 1; i <= ATT_ENTRIES; i++)
			exp_att[i] = '0; // deallocated, way and count zero
		repeat (3) @(posedge clk_i);
		#1;
		rst_ni = 1'b1;

		@(negedge clk_i); // reset values
		check_flag("awvalid", 1'b0, wr_reqpkt.awvalid);
		check_flag("wvalid", 1'b0, wr_reqpkt.wvalid);
		check_flag("tbl_update_done", 1'b0, tbl_update_done);
		check_flag("init_att_done", 1'b0, init_att_done);
		check_flag("init_list_done", 1'b0, init_list_done);
		check_flag("pgwr_mngr_ready", 1'b1, pgwr_mngr_ready);
		check_tol_ht("tol_ht", '0, tol_ht);

		drive_slot();
		init_att = 1'b1;
		@(negedge clk_i);
		while (!init_att_done)
			@(negedge clk_i);
		check_flag("init_list_done", 1'b0, init_list_done);
		drive_slot();
		init_att = 1'b0;
		compare_tables(1'b0); // list table not written yet

		drive_slot();
		init_list = 1'b1;
		@(negedge clk_i);
		while (!init_list_done)
			@(negedge clk_i);
		drive_slot();
		init_list = 1'b0;
		for (i = 1; i <= LIST_ENTRIES; i++)
			exp_list[i] = init_list_ref(i);
		exp_ht.free_head = ptr_t'(1);
		exp_ht.free_tail = ptr_t'(LIST_ENTRIES);
		check_flag("init_att_done", 1'b1, init_att_done);
		compare_tables(1'b1);

		for (i = 0; i < NUM_UPD; i++)
			run_update(i == 2); // first is the empty push

		repeat (10) @(posedge clk_i); // idle tail, nothing may move
		check_count("tbl_update_done pulses", NUM_UPD, done_cnt);
		check_count("stray memory writes", 0, u_mem.stray_cnt);
		compare_tables(1'b1);
		$display("run over: %0d value errors, %0d protocol errors", val_err, proto_err);
		if (val_err == 0 && proto_err == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// ==== files.f ====
rtl/pgwr_pkg.sv
rtl/pgwr_cmd_decode.sv
rtl/pgwr_line_build.sv
rtl/pgwr_axi_wr_issue.sv
rtl/tol_list_regs.sv
rtl/pgwr_mngr.sv
verification/pgwr_mem_model.sv
verification/tb_pgwr_mngr.sv

// ==== Makefile ====
# Verilator build and run for the page-table write manager
# override any variable on the command line, e.g. make run LOG=my.log

VERILATOR ?= verilator
TOP       ?= tb_pgwr_mngr
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= No errors
VFLAGS    ?= --binary --timing --assert

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then echo "simulation passed"; \
	else echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
